// File: Makefile
VERILATOR ?= verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps -j 0
TOP       = tb_iob_wb_subsystem
FILELIST  = list.f
BUILD_DIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: iob_pkg.sv
`include "iob_wb_config.svh"

package iob_pkg;

   // All zeros marks a read.
   typedef logic [`DATA_W/8-1:0] iob_strb_t;

   typedef enum logic {
      TGT_RAM  = 1'b0,
      TGT_REGS = 1'b1
   } iob_target_e;

   // Register block FSM, one wait state before the access.
   typedef enum logic [1:0] {
      REGS_IDLE = 2'd0,
      REGS_WAIT = 2'd1,
      REGS_RESP = 2'd2
   } regs_state_e;

   // Word 0 scratch, 1 inverse, 2 write counter.
   typedef logic [1:0] reg_idx_t;

endpackage

// File: iob_ram_slave.sv
`timescale 1ns/1ps
`include "iob_wb_config.svh"

module iob_ram_slave
   import wb_pkg::*, iob_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_n_i,

   input  logic      iob_avalid_i,
   input  wb_addr_t  iob_address_i,
   input  wb_data_t  iob_wdata_i,
   input  iob_strb_t iob_wstrb_i,
   output logic      iob_rvalid_o,
   output wb_data_t  iob_rdata_o
);

   localparam int WORD_AW = $clog2(`RAM_DEPTH);

   wb_data_t           mem [`RAM_DEPTH];
   logic [WORD_AW-1:0] word_addr;
   logic               rd_en;
   logic               rvalid_r;
   wb_data_t           rdata_r;

   assign word_addr = iob_address_i[WORD_AW+1:2];   // Byte address to word index.
   assign rd_en     = iob_avalid_i & ~(|iob_wstrb_i);

   always_ff @(posedge clk_i) begin
      if (iob_avalid_i) begin
         for (int b = 0; b < `DATA_W/8; b++) begin
            if (iob_wstrb_i[b]) begin
               mem[word_addr][b*8 +: 8] <= iob_wdata_i[b*8 +: 8];
            end
         end
      end
      if (rd_en) begin
         rdata_r <= mem[word_addr];
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         rvalid_r <= 1'b0;
      end else begin
         rvalid_r <= rd_en;                 // Single-cycle pulse.
      end
   end

   assign iob_rvalid_o = rvalid_r;
   assign iob_rdata_o  = rdata_r;

endmodule

// File: iob_regs_slave.sv
`timescale 1ns/1ps
`include "iob_wb_config.svh"

module iob_regs_slave
   import wb_pkg::*, iob_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_n_i,

   input  logic      iob_avalid_i,
   input  wb_addr_t  iob_address_i,
   input  wb_data_t  iob_wdata_i,
   input  iob_strb_t iob_wstrb_i,
   output logic      iob_ready_o,
   output logic      iob_rvalid_o,
   output wb_data_t  iob_rdata_o
);

   regs_state_e state_r;
   regs_state_e state_nxt;
   reg_idx_t    idx;
   logic        accept;
   logic        wr_en;
   wb_data_t    scratch_r;
   wb_data_t    wcnt_r;
   wb_data_t    rdata_r;

   assign idx          = iob_address_i[3:2];
   assign iob_ready_o  = (state_r == REGS_WAIT);
   assign accept       = iob_avalid_i & iob_ready_o;
   assign wr_en        = accept & (|iob_wstrb_i);
   assign iob_rvalid_o = (state_r == REGS_RESP);
   assign iob_rdata_o  = rdata_r;

   always_comb begin
      state_nxt = state_r;
      case (state_r)
         REGS_IDLE: if (iob_avalid_i) state_nxt = REGS_WAIT;
         REGS_WAIT: state_nxt = (accept && !wr_en) ? REGS_RESP : REGS_IDLE;
         REGS_RESP: state_nxt = REGS_IDLE;
         default:   state_nxt = REGS_IDLE;
      endcase
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_r   <= REGS_IDLE;
         scratch_r <= '0;
         wcnt_r    <= '0;
      end else begin
         state_r <= state_nxt;
         if (wr_en) begin
            wcnt_r <= wcnt_r + wb_data_t'(1);   // Writes to read-only words count as well.
            if (idx == 2'd0) begin
               for (int b = 0; b < `DATA_W/8; b++) begin
                  if (iob_wstrb_i[b]) begin
                     scratch_r[b*8 +: 8] <= iob_wdata_i[b*8 +: 8];
                  end
               end
            end
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept && !wr_en) begin
         case (idx)
            2'd0:    rdata_r <= scratch_r;
            2'd1:    rdata_r <= ~scratch_r;
            2'd2:    rdata_r <= wcnt_r;
            default: rdata_r <= '0;
         endcase
      end
   end

endmodule

// File: iob_slave_mux.sv
`timescale 1ns/1ps
`include "iob_wb_config.svh"

module iob_slave_mux
   import wb_pkg::*, iob_pkg::*;
(
   input  logic     clk_i,
   input  logic     rst_n_i,

   input  logic     iob_avalid_i,
   input  wb_addr_t iob_address_i,
   output logic     iob_ready_o,
   output logic     iob_rvalid_o,
   output wb_data_t iob_rdata_o,

   output logic     ram_avalid_o,
   input  logic     ram_rvalid_i,
   input  wb_data_t ram_rdata_i,

   output logic     regs_avalid_o,
   input  logic     regs_ready_i,
   input  logic     regs_rvalid_i,
   input  wb_data_t regs_rdata_i
);

   iob_target_e target;
   iob_target_e target_r;

   assign target = iob_address_i[`SEL_BIT] ? TGT_REGS : TGT_RAM;

   assign ram_avalid_o  = iob_avalid_i & (target == TGT_RAM);
   assign regs_avalid_o = iob_avalid_i & (target == TGT_REGS);

   // RAM never stalls.
   assign iob_ready_o = (target == TGT_RAM) ? 1'b1 : regs_ready_i;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         target_r <= TGT_RAM;
      end else if (iob_avalid_i && iob_ready_o) begin
         target_r <= target;                // Remembers who owes the response.
      end
   end

   always_comb begin
      if (target_r == TGT_RAM) begin
         iob_rvalid_o = ram_rvalid_i;
         iob_rdata_o  = ram_rdata_i;
      end else begin
         iob_rvalid_o = regs_rvalid_i;
         iob_rdata_o  = regs_rdata_i;
      end
   end

endmodule

// File: iob_wb_config.svh
`ifndef IOB_WB_CONFIG_SVH
`define IOB_WB_CONFIG_SVH

// Bus widths shared by the Wishbone and IOb sides.
`define ADDR_W 32
`define DATA_W 32

// Scratch RAM size in words.
`define RAM_DEPTH 256

// Address bit that picks the slave: 0 is the RAM, 1 is the register block.
`define SEL_BIT 12

`endif

// File: iob_wb_subsystem.sv
`timescale 1ns/1ps

module iob_wb_subsystem
   import wb_pkg::*, iob_pkg::*;
(
   input  logic     clk_i,
   input  logic     rst_n_i,

   input  logic     wb_cyc_i,
   input  logic     wb_stb_i,
   input  logic     wb_we_i,
   input  wb_addr_t wb_addr_i,
   input  wb_sel_t  wb_select_i,
   input  wb_data_t wb_data_i,
   output logic     wb_ack_o,
   output wb_data_t wb_data_o
);

   logic      iob_avalid;
   wb_addr_t  iob_address;
   wb_data_t  iob_wdata;
   iob_strb_t iob_wstrb;
   logic      iob_ready;
   logic      iob_rvalid;
   wb_data_t  iob_rdata;

   logic      ram_avalid;
   logic      ram_rvalid;
   wb_data_t  ram_rdata;

   logic      regs_avalid;
   logic      regs_ready;
   logic      regs_rvalid;
   wb_data_t  regs_rdata;

   iob_wishbone2iob u_bridge (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .wb_addr_i     (wb_addr_i),
      .wb_select_i   (wb_select_i),
      .wb_we_i       (wb_we_i),
      .wb_cyc_i      (wb_cyc_i),
      .wb_stb_i      (wb_stb_i),
      .wb_data_i     (wb_data_i),
      .wb_ack_o      (wb_ack_o),
      .wb_data_o     (wb_data_o),
      .iob_avalid_o  (iob_avalid),
      .iob_address_o (iob_address),
      .iob_wdata_o   (iob_wdata),
      .iob_wstrb_o   (iob_wstrb),
      .iob_rvalid_i  (iob_rvalid),
      .iob_rdata_i   (iob_rdata),
      .iob_ready_i   (iob_ready)
   );

   iob_slave_mux u_mux (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .iob_avalid_i  (iob_avalid),
      .iob_address_i (iob_address),
      .iob_ready_o   (iob_ready),
      .iob_rvalid_o  (iob_rvalid),
      .iob_rdata_o   (iob_rdata),
      .ram_avalid_o  (ram_avalid),
      .ram_rvalid_i  (ram_rvalid),
      .ram_rdata_i   (ram_rdata),
      .regs_avalid_o (regs_avalid),
      .regs_ready_i  (regs_ready),
      .regs_rvalid_i (regs_rvalid),
      .regs_rdata_i  (regs_rdata)
   );

   // Address, write data and strobes fan out to both slaves.
   iob_ram_slave u_ram (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .iob_avalid_i  (ram_avalid),
      .iob_address_i (iob_address),
      .iob_wdata_i   (iob_wdata),
      .iob_wstrb_i   (iob_wstrb),
      .iob_rvalid_o  (ram_rvalid),
      .iob_rdata_o   (ram_rdata)
   );

   iob_regs_slave u_regs (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .iob_avalid_i  (regs_avalid),
      .iob_address_i (iob_address),
      .iob_wdata_i   (iob_wdata),
      .iob_wstrb_i   (iob_wstrb),
      .iob_ready_o   (regs_ready),
      .iob_rvalid_o  (regs_rvalid),
      .iob_rdata_o   (regs_rdata)
   );

endmodule

// File: iob_wishbone2iob.sv
`timescale 1ns/1ps
`include "iob_wb_config.svh"

module iob_wishbone2iob
   import wb_pkg::*, iob_pkg::*;
(
   input  logic      clk_i,
   input  logic      rst_n_i,

   input  wb_addr_t  wb_addr_i,
   input  wb_sel_t   wb_select_i,
   input  logic      wb_we_i,
   input  logic      wb_cyc_i,
   input  logic      wb_stb_i,
   input  wb_data_t  wb_data_i,
   output logic      wb_ack_o,
   output wb_data_t  wb_data_o,

   output logic      iob_avalid_o,
   output wb_addr_t  iob_address_o,
   output wb_data_t  iob_wdata_o,
   output iob_strb_t iob_wstrb_o,
   input  logic      iob_rvalid_i,
   input  wb_data_t  iob_rdata_i,
   input  logic      iob_ready_i
);

   logic     done_r;
   logic     accept;
   logic     wack_r;
   wb_data_t rd_mask;

   // Request stays up until the slave takes it.
   assign iob_avalid_o  = wb_cyc_i & wb_stb_i & ~done_r;
   assign iob_address_o = wb_addr_i;
   assign iob_wdata_o   = wb_data_i;
   assign iob_wstrb_o   = wb_we_i ? wb_select_i : '0;

   assign accept = iob_avalid_o & iob_ready_i;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         done_r <= 1'b0;
         wack_r <= 1'b0;
      end else begin
         if (!wb_stb_i) begin
            done_r <= 1'b0;                   // Rearm once the strobe drops.
         end else if (accept) begin
            done_r <= 1'b1;
         end
         wack_r <= accept & (|iob_wstrb_o);   // Writes ack the cycle after acceptance.
      end
   end

   always_comb begin
      for (int b = 0; b < `DATA_W/8; b++) begin
         rd_mask[b*8 +: 8] = {8{wb_select_i[b]}};
      end
   end

   assign wb_data_o = iob_rdata_i & rd_mask;   // Unselected bytes read as zero.
   assign wb_ack_o  = wack_r | iob_rvalid_i;

endmodule

// File: list.f
+incdir+.
wb_pkg.sv
iob_pkg.sv
iob_wishbone2iob.sv
iob_ram_slave.sv
iob_regs_slave.sv
iob_slave_mux.sv
iob_wb_subsystem.sv
tb_clk_gen.sv
tb_iob_wb_subsystem.sv

// File: tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
   output logic clk_o,
   output logic rst_n_o
);

   initial begin
      clk_o   = 1'b0;
      rst_n_o = 1'b0;
      repeat (16) @(posedge clk_o);
      #1 rst_n_o = 1'b1;              // Released with the same skew as the stimulus.
   end

   always #2 clk_o = ~clk_o;          // 4 ns period.

endmodule

// File: tb_iob_wb_subsystem.sv
`timescale 1ns/1ps
`include "iob_wb_config.svh"

module tb_iob_wb_subsystem
   import wb_pkg::*, iob_pkg::*;
();

   localparam int RAM_WORDS = 16;                 // RAM words touched by the tests.
   localparam int N_RANDOM  = 400;
   localparam int N_XFERS   = 2*RAM_WORDS + 16 + 12 + 7 + N_RANDOM;
   localparam int TIMEOUT   = N_XFERS*8 + 200;

   logic     clk;
   logic     rst_n;
   logic     cyc;
   logic     stb;
   logic     we;
   wb_addr_t addr;
   wb_sel_t  sel;
   wb_data_t wdata;
   logic     ack;
   wb_data_t rdata;

   wb_data_t ram_m [RAM_WORDS];
   wb_data_t scratch_m = '0;
   wb_data_t wcnt_m = '0;
   int       cycle_cnt = 0;

   tb_clk_gen u_clk (.clk_o(clk), .rst_n_o(rst_n));

   iob_wb_subsystem uut (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .wb_cyc_i    (cyc),
      .wb_stb_i    (stb),
      .wb_we_i     (we),
      .wb_addr_i   (addr),
      .wb_select_i (sel),
      .wb_data_i   (wdata),
      .wb_ack_o    (ack),
      .wb_data_o   (rdata)
   );

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Verification failed");
      $fatal(1, "run stopped at the first error");
   endtask

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > TIMEOUT) fail_run("timeout: the tests did not complete in time");
   end

   task automatic check_data(input wb_data_t got, input wb_data_t exp, input string what);
      if (got !== exp)
         fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
   endtask

   task automatic check_latency(input int got, input int exp, input string what);
      if (got != exp)
         fail_run($sformatf("mismatch at %0t: %s ack after %0d cycles, expected %0d",
                            $time, what, got, exp));
   endtask

   function automatic wb_data_t byte_mask(input wb_sel_t s);
      wb_data_t m;
      for (int b = 0; b < `DATA_W/8; b++) m[b*8 +: 8] = {8{s[b]}};
      return m;
   endfunction

   function automatic wb_data_t merge(input wb_data_t old, input wb_data_t nw, input wb_sel_t s);
      return (old & ~byte_mask(s)) | (nw & byte_mask(s));
   endfunction

   function automatic iob_target_e target_of(input wb_addr_t a);
      return a[`SEL_BIT] ? TGT_REGS : TGT_RAM;
   endfunction

   // Upper bits come from hi and must not affect the decode.
   function automatic wb_addr_t make_addr(input iob_target_e t, input int word, input wb_addr_t hi);
      wb_addr_t a;
      a = hi;
      a[`SEL_BIT] = (t == TGT_REGS);
      a[`SEL_BIT-1:0] = `SEL_BIT'(word*4);
      return a;
   endfunction

   function automatic wb_data_t expected_read(input wb_addr_t a);
      if (target_of(a) == TGT_RAM) return ram_m[int'(a[`SEL_BIT-1:2])];
      case (a[3:2])
         2'd0:    return scratch_m;
         2'd1:    return ~scratch_m;
         2'd2:    return wcnt_m;
         default: return '0;
      endcase
   endfunction

   task automatic wb_transfer(input logic w, input wb_addr_t a, input wb_data_t d,
                              input wb_sel_t s, output wb_data_t q, output int cycles);
      logic got_ack;
      got_ack = 1'b0;
      cycles  = 0;
      @(posedge clk);
      #1;
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = w;
      addr  = a;
      sel   = s;
      wdata = d;
      while (!got_ack) begin
         @(negedge clk);                       // Mid-cycle, after the combinational ack settles.
         if (ack) begin
            got_ack = 1'b1;
            q       = rdata;
         end else begin
            cycles++;
         end
      end
      @(posedge clk);
      #1;
      cyc = 1'b0;
      stb = 1'b0;
      we  = 1'b0;
   endtask

   task automatic wb_write(input wb_addr_t a, input wb_data_t d, input wb_sel_t s,
                           output int cycles);
      wb_data_t unused_q;
      wb_transfer(1'b1, a, d, s, unused_q, cycles);
   endtask

   task automatic wb_read(input wb_addr_t a, input wb_sel_t s, output wb_data_t q,
                          output int cycles);
      wb_transfer(1'b0, a, '0, s, q, cycles);
   endtask

   task automatic do_write(input wb_addr_t a, input wb_data_t d, input wb_sel_t s);
      int lat;
      wb_write(a, d, s, lat);
      check_latency(lat, (target_of(a) == TGT_RAM) ? 1 : 2, $sformatf("write to %h", a));
      if (target_of(a) == TGT_RAM) begin
         ram_m[int'(a[`SEL_BIT-1:2])] = merge(ram_m[int'(a[`SEL_BIT-1:2])], d, s);
      end else begin
         wcnt_m = wcnt_m + 1;                   // Every register write counts.
         if (a[3:2] == 2'd0) scratch_m = merge(scratch_m, d, s);
      end
   endtask

   task automatic do_read(input wb_addr_t a, input wb_sel_t s);
      wb_data_t q;
      int       lat;
      wb_read(a, s, q, lat);
      check_latency(lat, (target_of(a) == TGT_RAM) ? 1 : 2, $sformatf("read of %h", a));
      check_data(q, expected_read(a) & byte_mask(s), $sformatf("read of %h", a));
   endtask

   task automatic test_ram_words();
      for (int i = 0; i < RAM_WORDS; i++) do_write(make_addr(TGT_RAM, i, '0), $urandom, 4'hF);
      for (int i = 0; i < RAM_WORDS; i++) do_read(make_addr(TGT_RAM, i, '0), 4'hF);
   endtask

   task automatic test_byte_strobes();
      wb_addr_t a;
      for (int w = 2; w < 6; w++) begin
         a = make_addr(TGT_RAM, w, '0);
         do_write(a, $urandom, wb_sel_t'(1 << (w % 4)));
         do_write(a, $urandom, (w % 2 == 1) ? 4'hC : 4'h3);
         do_read(a, 4'hF);
         do_read(a, 4'h6);                      // Bytes 0 and 3 must read as zero.
      end
   endtask

   task automatic test_scratch();
      wb_sel_t sels [4] = '{4'hF, 4'h2, 4'hC, 4'h5};
      foreach (sels[i]) begin
         do_write(make_addr(TGT_REGS, 0, '0), $urandom, sels[i]);
         do_read(make_addr(TGT_REGS, 0, '0), 4'hF);
         do_read(make_addr(TGT_REGS, 1, '0), 4'hF);
      end
   endtask

   task automatic test_write_counter();
      do_read(make_addr(TGT_REGS, 2, '0), 4'hF);
      for (int w = 1; w < 4; w++) do_write(make_addr(TGT_REGS, w, '0), $urandom, 4'hF);
      do_write(make_addr(TGT_RAM, 0, '0), $urandom, 4'hF);
      do_write(make_addr(TGT_RAM, 1, '0), $urandom, 4'hF);
      do_read(make_addr(TGT_REGS, 2, '0), 4'hF);
   endtask

   task automatic test_random();
      iob_target_e t;
      int          w;
      wb_addr_t    a;
      wb_sel_t     s;
      for (int n = 0; n < N_RANDOM; n++) begin
         t = ($urandom_range(0, 1) == 1) ? TGT_REGS : TGT_RAM;
         w = (t == TGT_REGS) ? int'($urandom_range(0, 3)) : int'($urandom_range(0, RAM_WORDS-1));
         a = make_addr(t, w, $urandom);
         s = wb_sel_t'($urandom_range(1, 15));
         if ($urandom_range(0, 1) == 1) do_write(a, $urandom, s);
         else do_read(a, s);
      end
   endtask

   initial begin
      void'($urandom(32'h1aec_62cc));
      cyc   = 1'b0;
      stb   = 1'b0;
      we    = 1'b0;
      addr  = '0;
      sel   = '0;
      wdata = '0;
      wait (rst_n === 1'b1);
      test_ram_words();
      test_byte_strobes();
      test_scratch();
      test_write_counter();
      test_random();
      $display("Verification passed");
      $finish;
   end

endmodule

// File: wb_pkg.sv
`include "iob_wb_config.svh"

package wb_pkg;

   // Byte address as seen on the Wishbone side.
   typedef logic [`ADDR_W-1:0] wb_addr_t;

   typedef logic [`DATA_W-1:0] wb_data_t;

   // One select bit per data byte.
   typedef logic [`DATA_W/8-1:0] wb_sel_t;

endpackage
